// File: run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$output"; then
  exit 0
fi
exit 1

// File: source/cce_cfg.svh
// widths and counts for the GPR file, addresses, LCEs, ways and MSHR flags
`ifndef CCE_CFG_SVH
`define CCE_CFG_SVH

// GPR file and ALU operand
`define CCE_GPR_WIDTH 64
`define CCE_NUM_GPR 8
`define CCE_GPR_SEL_WIDTH 3

// physical address
`define CCE_PADDR_WIDTH 40

// LCEs tracked by the directory
`define CCE_NUM_LCE 4
`define CCE_LCE_ID_WIDTH 2

// 8-way associativity
`define CCE_WAY_WIDTH 3

// MSHR flag bits
`define CCE_NUM_FLAGS 13

`endif

// File: source/cce_fu_sel.sv
// address with bypass, LCE id, way, LRU way and coherence state selection
`default_nettype none

`include "cce_cfg.svh"

module cce_fu_sel (
  input  cce_pkg::cce_mux_sel_addr_e  addr_sel_i,
  input  cce_pkg::cce_mux_sel_lce_e   lce_sel_i,
  input  cce_pkg::cce_mux_sel_way_e   way_sel_i,
  input  cce_pkg::cce_mux_sel_way_e   lru_way_sel_i,
  input  cce_pkg::cce_mux_sel_coh_e   coh_state_sel_i,
  cce_src_if.sel                      src,
  cce_sel_out_if.src                  fu
);

  localparam int COH_W = $bits(cce_pkg::cce_coh_state_e);

  // way candidates indexed by the way select code
  logic [`CCE_WAY_WIDTH-1:0] way_opts [16];
  logic [COH_W-1:0]          state_raw;

  always_comb begin
    fu.addr        = '0;
    fu.addr_bypass = 1'b0;
    case (addr_sel_i) inside
      [cce_pkg::e_mux_sel_addr_r0:cce_pkg::e_mux_sel_addr_r7]: begin
        fu.addr        = src.gpr[addr_sel_i[2:0]][`CCE_PADDR_WIDTH-1:0];
        fu.addr_bypass = 1'b1;
      end
      cce_pkg::e_mux_sel_addr_mshr_req: fu.addr = src.mshr.paddr;
      cce_pkg::e_mux_sel_addr_mshr_lru: fu.addr = src.mshr.lru_paddr;
      cce_pkg::e_mux_sel_addr_0:        fu.addr_bypass = 1'b1;
      default:                          fu.addr = '0;
    endcase
  end

  always_comb begin
    case (lce_sel_i) inside
      [cce_pkg::e_mux_sel_lce_r0:cce_pkg::e_mux_sel_lce_r7]:
        fu.lce = src.gpr[lce_sel_i[2:0]][`CCE_LCE_ID_WIDTH-1:0];
      cce_pkg::e_mux_sel_lce_mshr_req:   fu.lce = src.mshr.lce_id;
      cce_pkg::e_mux_sel_lce_mshr_owner: fu.lce = src.mshr.owner_lce_id;
      default:                           fu.lce = '0;
    endcase
  end

  // shared by way and lru_way
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      way_opts[i] = '0;
    end
    for (int r = 0; r < `CCE_NUM_GPR; r++) begin
      way_opts[r] = src.gpr[r][`CCE_WAY_WIDTH-1:0];
    end
    way_opts[cce_pkg::e_mux_sel_way_mshr_req]   = src.mshr.way_id;
    way_opts[cce_pkg::e_mux_sel_way_mshr_owner] = src.mshr.owner_way_id;
    way_opts[cce_pkg::e_mux_sel_way_mshr_lru]   = src.mshr.lru_way_id;
    way_opts[cce_pkg::e_mux_sel_way_sh_way]     = src.sh_b_way;
  end

  assign fu.way     = way_opts[way_sel_i];
  assign fu.lru_way = way_opts[lru_way_sel_i];

  always_comb begin
    case (coh_state_sel_i) inside
      [cce_pkg::e_mux_sel_coh_r0:cce_pkg::e_mux_sel_coh_r7]:
        state_raw = src.gpr[coh_state_sel_i[2:0]][COH_W-1:0];
      cce_pkg::e_mux_sel_coh_next:   state_raw = src.mshr.next_coh_state;
      cce_pkg::e_mux_sel_coh_lru:    state_raw = src.mshr.lru_coh_state;
      cce_pkg::e_mux_sel_coh_sharer: state_raw = src.sh_b_state;
      cce_pkg::e_mux_sel_coh_owner:  state_raw = src.mshr.owner_coh_state;
      cce_pkg::e_mux_sel_coh_imm:    state_raw = src.imm[COH_W-1:0];
      default:                       state_raw = cce_pkg::e_coh_i;
    endcase
    // encodings 6 and 7 are no coherence state, read them as I
    if (state_raw > COH_W'(cce_pkg::e_coh_f)) begin
      fu.state = cce_pkg::e_coh_i;
    end else begin
      fu.state = cce_pkg::cce_coh_state_e'(state_raw);
    end
  end

endmodule

`default_nettype wire

// File: source/cce_operand_sel.sv
// one ALU operand from GPR, flag, MSHR field, sharers, immediate or zero
`default_nettype none

`include "cce_cfg.svh"

module cce_operand_sel #(
  parameter bit SHARERS_EN = 1'b1
) (
  input  cce_pkg::cce_src_sel_e       sel_i,
  input  cce_pkg::cce_opd_t           opd_i,
  cce_src_if.sel                      src,
  output logic [`CCE_GPR_WIDTH-1:0]   operand_o
);

  localparam int COH_W = $bits(cce_pkg::cce_coh_state_e);

  always_comb begin
    operand_o = '0;
    case (sel_i)
      cce_pkg::e_src_sel_gpr: begin
        // codes 8 and up name no register
        if (opd_i < `CCE_NUM_GPR) begin
          operand_o = src.gpr[opd_i[`CCE_GPR_SEL_WIDTH-1:0]];
        end
      end
      cce_pkg::e_src_sel_flag: begin
        if (opd_i < `CCE_NUM_FLAGS) begin
          operand_o[0] = src.mshr.flags[opd_i];
        end
      end
      cce_pkg::e_src_sel_special: begin
        case (cce_pkg::cce_opd_special_e'(opd_i))
          cce_pkg::e_opd_req_lce:
            operand_o[`CCE_LCE_ID_WIDTH-1:0] = src.mshr.lce_id;
          cce_pkg::e_opd_req_addr:
            operand_o[`CCE_PADDR_WIDTH-1:0] = src.mshr.paddr;
          cce_pkg::e_opd_req_way:
            operand_o[`CCE_WAY_WIDTH-1:0] = src.mshr.way_id;
          cce_pkg::e_opd_lru_addr:
            operand_o[`CCE_PADDR_WIDTH-1:0] = src.mshr.lru_paddr;
          cce_pkg::e_opd_lru_way:
            operand_o[`CCE_WAY_WIDTH-1:0] = src.mshr.lru_way_id;
          cce_pkg::e_opd_owner_lce:
            operand_o[`CCE_LCE_ID_WIDTH-1:0] = src.mshr.owner_lce_id;
          cce_pkg::e_opd_owner_way:
            operand_o[`CCE_WAY_WIDTH-1:0] = src.mshr.owner_way_id;
          cce_pkg::e_opd_next_coh_state:
            operand_o[COH_W-1:0] = src.mshr.next_coh_state;
          // flags masked by the immediate
          cce_pkg::e_opd_flags:
            operand_o[`CCE_NUM_FLAGS-1:0] = src.mshr.flags & src.imm[`CCE_NUM_FLAGS-1:0];
          cce_pkg::e_opd_lru_coh_state:
            operand_o[COH_W-1:0] = src.mshr.lru_coh_state;
          cce_pkg::e_opd_owner_coh_state:
            operand_o[COH_W-1:0] = src.mshr.owner_coh_state;
          // sharers results only exist on the src_a side
          cce_pkg::e_opd_sharers_hit:
            operand_o[0] = SHARERS_EN & src.sh_a_hit;
          cce_pkg::e_opd_sharers_way:
            operand_o[`CCE_WAY_WIDTH-1:0] = SHARERS_EN ? src.sh_a_way : '0;
          cce_pkg::e_opd_sharers_state:
            operand_o[COH_W-1:0] = SHARERS_EN ? src.sh_a_state : cce_pkg::e_coh_i;
          default:
            operand_o = '0;
        endcase
      end
      cce_pkg::e_src_sel_imm: begin
        operand_o = src.imm;
      end
      default: begin
        operand_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/cce_pkg.sv
// select enums, operand codes, coherence states and the MSHR struct
`default_nettype none

`include "cce_cfg.svh"

package cce_pkg;

  // source group for an ALU operand
  typedef enum logic [2:0] {
    e_src_sel_gpr,
    e_src_sel_flag,
    e_src_sel_special,
    e_src_sel_imm,
    e_src_sel_zero
  } cce_src_sel_e;

  // meaning depends on the source group
  typedef logic [3:0] cce_opd_t;

  typedef enum logic [3:0] {
    e_opd_req_lce,
    e_opd_req_addr,
    e_opd_req_way,
    e_opd_lru_addr,
    e_opd_lru_way,
    e_opd_owner_lce,
    e_opd_owner_way,
    e_opd_next_coh_state,
    e_opd_flags,
    e_opd_lru_coh_state,
    e_opd_owner_coh_state,
    e_opd_sharers_hit,
    e_opd_sharers_way,
    e_opd_sharers_state
  } cce_opd_special_e;

  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s,
    e_coh_e,
    e_coh_m,
    e_coh_o,
    e_coh_f
  } cce_coh_state_e;

  // function unit selects, r0..r7 always occupy codes 0..7
  typedef enum logic [3:0] {
    e_mux_sel_addr_r0, e_mux_sel_addr_r1, e_mux_sel_addr_r2, e_mux_sel_addr_r3,
    e_mux_sel_addr_r4, e_mux_sel_addr_r5, e_mux_sel_addr_r6, e_mux_sel_addr_r7,
    e_mux_sel_addr_mshr_req,
    e_mux_sel_addr_mshr_lru,
    e_mux_sel_addr_0
  } cce_mux_sel_addr_e;

  typedef enum logic [3:0] {
    e_mux_sel_lce_r0, e_mux_sel_lce_r1, e_mux_sel_lce_r2, e_mux_sel_lce_r3,
    e_mux_sel_lce_r4, e_mux_sel_lce_r5, e_mux_sel_lce_r6, e_mux_sel_lce_r7,
    e_mux_sel_lce_mshr_req,
    e_mux_sel_lce_mshr_owner,
    e_mux_sel_lce_0
  } cce_mux_sel_lce_e;

  typedef enum logic [3:0] {
    e_mux_sel_way_r0, e_mux_sel_way_r1, e_mux_sel_way_r2, e_mux_sel_way_r3,
    e_mux_sel_way_r4, e_mux_sel_way_r5, e_mux_sel_way_r6, e_mux_sel_way_r7,
    e_mux_sel_way_mshr_req,
    e_mux_sel_way_mshr_owner,
    e_mux_sel_way_mshr_lru,
    e_mux_sel_way_sh_way,
    e_mux_sel_way_0
  } cce_mux_sel_way_e;

  typedef enum logic [3:0] {
    e_mux_sel_coh_r0, e_mux_sel_coh_r1, e_mux_sel_coh_r2, e_mux_sel_coh_r3,
    e_mux_sel_coh_r4, e_mux_sel_coh_r5, e_mux_sel_coh_r6, e_mux_sel_coh_r7,
    e_mux_sel_coh_next,
    e_mux_sel_coh_lru,
    e_mux_sel_coh_sharer,
    e_mux_sel_coh_owner,
    e_mux_sel_coh_imm
  } cce_mux_sel_coh_e;

  typedef struct packed {
    logic [`CCE_LCE_ID_WIDTH-1:0] lce_id;
    logic [`CCE_LCE_ID_WIDTH-1:0] owner_lce_id;
    logic [`CCE_PADDR_WIDTH-1:0]  paddr;
    logic [`CCE_PADDR_WIDTH-1:0]  lru_paddr;
    logic [`CCE_WAY_WIDTH-1:0]    way_id;
    logic [`CCE_WAY_WIDTH-1:0]    lru_way_id;
    logic [`CCE_WAY_WIDTH-1:0]    owner_way_id;
    cce_coh_state_e               next_coh_state;
    cce_coh_state_e               lru_coh_state;
    cce_coh_state_e               owner_coh_state;
    logic [`CCE_NUM_FLAGS-1:0]    flags;
  } cce_mshr_s;

endpackage

`default_nettype wire

// File: source/cce_sel_reg.sv
// output register stage for operands and function unit selects, with assertions
`default_nettype none

`include "cce_cfg.svh"

module cce_sel_reg (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [`CCE_GPR_WIDTH-1:0]     src_a_i,
  input  logic [`CCE_GPR_WIDTH-1:0]     src_b_i,
  cce_sel_out_if.dst                    fu,
  output logic [`CCE_GPR_WIDTH-1:0]     src_a_o,
  output logic [`CCE_GPR_WIDTH-1:0]     src_b_o,
  output logic [`CCE_PADDR_WIDTH-1:0]   addr_o,
  output logic                          addr_bypass_o,
  output logic [`CCE_LCE_ID_WIDTH-1:0]  lce_o,
  output logic [`CCE_WAY_WIDTH-1:0]     way_o,
  output logic [`CCE_WAY_WIDTH-1:0]     lru_way_o,
  output cce_pkg::cce_coh_state_e       state_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_a_o       <= '0;
      src_b_o       <= '0;
      addr_o        <= '0;
      addr_bypass_o <= 1'b0;
      lce_o         <= '0;
      way_o         <= '0;
      lru_way_o     <= '0;
      state_o       <= cce_pkg::e_coh_i;
    end else begin
      src_a_o       <= src_a_i;
      src_b_o       <= src_b_i;
      addr_o        <= fu.addr;
      addr_bypass_o <= fu.addr_bypass;
      lce_o         <= fu.lce;
      way_o         <= fu.way;
      lru_way_o     <= fu.lru_way;
      state_o       <= fu.state;
    end
  end

  // fu_sel folds GPR and immediate encodings above F back to I
  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) state_o <= cce_pkg::e_coh_f
  );

  a_bypass_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !$isunknown(addr_bypass_o)
  );

  // MSHR address was captured, so the upper half must be defined
  a_mshr_addr_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      !addr_bypass_o |-> !$isunknown(addr_o[`CCE_PADDR_WIDTH-1:`CCE_PADDR_WIDTH/2])
  );

endmodule

`default_nettype wire

// File: source/cce_sharer_lookup.sv
// sharers hit, way and state lookup for the LCE held in one GPR
`default_nettype none

`include "cce_cfg.svh"

module cce_sharer_lookup #(
  // 0 drives the sh_a group, 1 the sh_b group
  parameter bit SIDE = 1'b0
) (
  input  logic [`CCE_GPR_SEL_WIDTH-1:0]                  gpr_sel_i,
  input  logic [`CCE_NUM_LCE-1:0]                        sharers_hits_i,
  input  logic [`CCE_NUM_LCE-1:0][`CCE_WAY_WIDTH-1:0]    sharers_ways_i,
  input  cce_pkg::cce_coh_state_e [`CCE_NUM_LCE-1:0]     sharers_coh_states_i,
  cce_src_if.lookup                                      src
);

  logic [`CCE_LCE_ID_WIDTH-1:0] lce_idx;

  // LCE id sits in the low bits of the register
  assign lce_idx = src.gpr[gpr_sel_i][`CCE_LCE_ID_WIDTH-1:0];

  if (SIDE == 1'b0) begin : g_side_a
    assign src.sh_a_hit   = sharers_hits_i[lce_idx];
    assign src.sh_a_way   = sharers_ways_i[lce_idx];
    assign src.sh_a_state = sharers_coh_states_i[lce_idx];
  end else begin : g_side_b
    assign src.sh_b_hit   = sharers_hits_i[lce_idx];
    assign src.sh_b_way   = sharers_ways_i[lce_idx];
    assign src.sh_b_state = sharers_coh_states_i[lce_idx];
  end

endmodule

`default_nettype wire

// File: source/cce_src_if.sv
// interfaces for selector sources and function unit select results
`default_nettype none

`include "cce_cfg.svh"

interface cce_src_if;
  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr;
  cce_pkg::cce_mshr_s                          mshr;
  logic [`CCE_GPR_WIDTH-1:0]                   imm;

  // group a is indexed by the src_b GPR, group b by the src_a GPR
  logic                    sh_a_hit;
  logic [`CCE_WAY_WIDTH-1:0] sh_a_way;
  cce_pkg::cce_coh_state_e sh_a_state;
  logic                    sh_b_hit;
  logic [`CCE_WAY_WIDTH-1:0] sh_b_way;
  cce_pkg::cce_coh_state_e sh_b_state;

  modport lookup (
    input  gpr,
    output sh_a_hit, sh_a_way, sh_a_state,
    output sh_b_hit, sh_b_way, sh_b_state
  );

  modport sel (
    input gpr, mshr, imm,
    input sh_a_hit, sh_a_way, sh_a_state,
    input sh_b_hit, sh_b_way, sh_b_state
  );
endinterface

interface cce_sel_out_if;
  logic [`CCE_PADDR_WIDTH-1:0]  addr;
  logic                         addr_bypass;
  logic [`CCE_LCE_ID_WIDTH-1:0] lce;
  logic [`CCE_WAY_WIDTH-1:0]    way;
  logic [`CCE_WAY_WIDTH-1:0]    lru_way;
  cce_pkg::cce_coh_state_e      state;

  modport src (output addr, addr_bypass, lce, way, lru_way, state);
  modport dst (input addr, addr_bypass, lce, way, lru_way, state);
endinterface

`default_nettype wire

// File: source/cce_src_sel_top.sv
// top level of the source select stage with sharers lookups, selectors and output register
`default_nettype none

`include "cce_cfg.svh"

module cce_src_sel_top (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  cce_pkg::cce_src_sel_e                        src_a_sel_i,
  input  cce_pkg::cce_src_sel_e                        src_b_sel_i,
  input  cce_pkg::cce_opd_t                            src_a_i,
  input  cce_pkg::cce_opd_t                            src_b_i,
  input  cce_pkg::cce_mux_sel_addr_e                   addr_sel_i,
  input  cce_pkg::cce_mux_sel_lce_e                    lce_sel_i,
  input  cce_pkg::cce_mux_sel_way_e                    way_sel_i,
  input  cce_pkg::cce_mux_sel_way_e                    lru_way_sel_i,
  input  cce_pkg::cce_mux_sel_coh_e                    coh_state_sel_i,
  input  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0]  gpr_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                    imm_i,
  input  cce_pkg::cce_mshr_s                           mshr_i,
  input  logic [`CCE_NUM_LCE-1:0]                      sharers_hits_i,
  input  logic [`CCE_NUM_LCE-1:0][`CCE_WAY_WIDTH-1:0]  sharers_ways_i,
  input  cce_pkg::cce_coh_state_e [`CCE_NUM_LCE-1:0]   sharers_coh_states_i,
  output logic [`CCE_GPR_WIDTH-1:0]                    src_a_o,
  output logic [`CCE_GPR_WIDTH-1:0]                    src_b_o,
  output logic [`CCE_PADDR_WIDTH-1:0]                  addr_o,
  output logic                                         addr_bypass_o,
  output logic [`CCE_LCE_ID_WIDTH-1:0]                 lce_o,
  output logic [`CCE_WAY_WIDTH-1:0]                    way_o,
  output logic [`CCE_WAY_WIDTH-1:0]                    lru_way_o,
  output cce_pkg::cce_coh_state_e                      state_o
);

  cce_src_if     src_if ();
  cce_sel_out_if out_if ();

  logic [`CCE_GPR_WIDTH-1:0] src_a_comb;
  logic [`CCE_GPR_WIDTH-1:0] src_b_comb;

  assign src_if.gpr  = gpr_i;
  assign src_if.mshr = mshr_i;
  assign src_if.imm  = imm_i;

  // group a follows the src_b register code, group b the src_a code
  cce_sharer_lookup #(.SIDE(1'b0)) u_lookup_a (
    .gpr_sel_i            (src_b_i[`CCE_GPR_SEL_WIDTH-1:0]),
    .sharers_hits_i       (sharers_hits_i),
    .sharers_ways_i       (sharers_ways_i),
    .sharers_coh_states_i (sharers_coh_states_i),
    .src                  (src_if.lookup)
  );

  cce_sharer_lookup #(.SIDE(1'b1)) u_lookup_b (
    .gpr_sel_i            (src_a_i[`CCE_GPR_SEL_WIDTH-1:0]),
    .sharers_hits_i       (sharers_hits_i),
    .sharers_ways_i       (sharers_ways_i),
    .sharers_coh_states_i (sharers_coh_states_i),
    .src                  (src_if.lookup)
  );

  cce_operand_sel #(.SHARERS_EN(1'b1)) u_opd_a (
    .sel_i     (src_a_sel_i),
    .opd_i     (src_a_i),
    .src       (src_if.sel),
    .operand_o (src_a_comb)
  );

  // no sharers sources on src_b
  cce_operand_sel #(.SHARERS_EN(1'b0)) u_opd_b (
    .sel_i     (src_b_sel_i),
    .opd_i     (src_b_i),
    .src       (src_if.sel),
    .operand_o (src_b_comb)
  );

  cce_fu_sel u_fu_sel (
    .addr_sel_i      (addr_sel_i),
    .lce_sel_i       (lce_sel_i),
    .way_sel_i       (way_sel_i),
    .lru_way_sel_i   (lru_way_sel_i),
    .coh_state_sel_i (coh_state_sel_i),
    .src             (src_if.sel),
    .fu              (out_if.src)
  );

  cce_sel_reg u_sel_reg (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .src_a_i       (src_a_comb),
    .src_b_i       (src_b_comb),
    .fu            (out_if.dst),
    .src_a_o       (src_a_o),
    .src_b_o       (src_b_o),
    .addr_o        (addr_o),
    .addr_bypass_o (addr_bypass_o),
    .lce_o         (lce_o),
    .way_o         (way_o),
    .lru_way_o     (lru_way_o),
    .state_o       (state_o)
  );

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/cce_pkg.sv
source/cce_src_if.sv
source/cce_sharer_lookup.sv
source/cce_operand_sel.sv
source/cce_fu_sel.sv
source/cce_sel_reg.sv
source/cce_src_sel_top.sv
tb/tb_clk_gen.sv
tb/tb_top.sv

// File: tb/tb_clk_gen.sv
// free running clock source for the testbench
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
// testbench top with DUT, reference model, directed tests, checker and timeout
`default_nettype none

`include "cce_cfg.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  // tests take roughly 160 cycles, the rest is margin
  localparam int MAX_CYCLES   = 2000;
  localparam int RESET_CYCLES = 8;

  logic clk_i;
  logic arst_n_i;

  cce_pkg::cce_src_sel_e      src_a_sel;
  cce_pkg::cce_src_sel_e      src_b_sel;
  cce_pkg::cce_opd_t          src_a;
  cce_pkg::cce_opd_t          src_b;
  cce_pkg::cce_mux_sel_addr_e addr_sel;
  cce_pkg::cce_mux_sel_lce_e  lce_sel;
  cce_pkg::cce_mux_sel_way_e  way_sel;
  cce_pkg::cce_mux_sel_way_e  lru_way_sel;
  cce_pkg::cce_mux_sel_coh_e  coh_sel;
  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr;
  logic [`CCE_GPR_WIDTH-1:0]                   imm;
  cce_pkg::cce_mshr_s                          mshr;
  logic [`CCE_NUM_LCE-1:0]                     sh_hits;
  logic [`CCE_NUM_LCE-1:0][`CCE_WAY_WIDTH-1:0] sh_ways;
  cce_pkg::cce_coh_state_e [`CCE_NUM_LCE-1:0]  sh_states;

  logic [`CCE_GPR_WIDTH-1:0]    src_a_o;
  logic [`CCE_GPR_WIDTH-1:0]    src_b_o;
  logic [`CCE_PADDR_WIDTH-1:0]  addr_o;
  logic                         addr_bypass_o;
  logic [`CCE_LCE_ID_WIDTH-1:0] lce_o;
  logic [`CCE_WAY_WIDTH-1:0]    way_o;
  logic [`CCE_WAY_WIDTH-1:0]    lru_way_o;
  cce_pkg::cce_coh_state_e      state_o;

  // model results for the inputs of the current cycle
  logic [`CCE_GPR_WIDTH-1:0]    exp_src_a;
  logic [`CCE_GPR_WIDTH-1:0]    exp_src_b;
  logic [`CCE_PADDR_WIDTH-1:0]  exp_addr;
  logic                         exp_bypass;
  logic [`CCE_LCE_ID_WIDTH-1:0] exp_lce;
  logic [`CCE_WAY_WIDTH-1:0]    exp_way;
  logic [`CCE_WAY_WIDTH-1:0]    exp_lru_way;
  logic [2:0]                   exp_state;

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;

  tb_clk_gen #(.PERIOD_NS(10)) u_clk_gen (.clk_o(clk_i));

  cce_src_sel_top dut (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .src_a_sel_i          (src_a_sel),
    .src_b_sel_i          (src_b_sel),
    .src_a_i              (src_a),
    .src_b_i              (src_b),
    .addr_sel_i           (addr_sel),
    .lce_sel_i            (lce_sel),
    .way_sel_i            (way_sel),
    .lru_way_sel_i        (lru_way_sel),
    .coh_state_sel_i      (coh_sel),
    .gpr_i                (gpr),
    .imm_i                (imm),
    .mshr_i               (mshr),
    .sharers_hits_i       (sh_hits),
    .sharers_ways_i       (sh_ways),
    .sharers_coh_states_i (sh_states),
    .src_a_o              (src_a_o),
    .src_b_o              (src_b_o),
    .addr_o               (addr_o),
    .addr_bypass_o        (addr_bypass_o),
    .lce_o                (lce_o),
    .way_o                (way_o),
    .lru_way_o            (lru_way_o),
    .state_o              (state_o)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
    end
  endtask

  task automatic check_outputs();
    check_value("src_a_o", src_a_o, exp_src_a);
    check_value("src_b_o", src_b_o, exp_src_b);
    check_value("addr_o", 64'(addr_o), 64'(exp_addr));
    check_value("addr_bypass_o", 64'(addr_bypass_o), 64'(exp_bypass));
    check_value("lce_o", 64'(lce_o), 64'(exp_lce));
    check_value("way_o", 64'(way_o), 64'(exp_way));
    check_value("lru_way_o", 64'(lru_way_o), 64'(exp_lru_way));
    check_value("state_o", 64'(state_o), 64'(exp_state));
  endtask

  function automatic cce_pkg::cce_coh_state_e rand_state();
    return cce_pkg::cce_coh_state_e'(3'($unsigned($random(seed)) % 6));
  endfunction

  // LCE id held in the low bits of the register a select code names
  function automatic int lce_of_gpr(input int code);
    return int'(gpr[code % `CCE_NUM_GPR][`CCE_LCE_ID_WIDTH-1:0]);
  endfunction

  function automatic logic [63:0] model_operand(input int sel, input int code,
                                                input bit sh_en, input int lce);
    logic [63:0] v;
    v = '0;
    case (sel)
      0: if (code < `CCE_NUM_GPR) v = gpr[code];
      1: if (code < `CCE_NUM_FLAGS) v[0] = mshr.flags[code];
      2: begin
        case (code)
          0:  v = 64'(mshr.lce_id);
          1:  v = 64'(mshr.paddr);
          2:  v = 64'(mshr.way_id);
          3:  v = 64'(mshr.lru_paddr);
          4:  v = 64'(mshr.lru_way_id);
          5:  v = 64'(mshr.owner_lce_id);
          6:  v = 64'(mshr.owner_way_id);
          7:  v = 64'(mshr.next_coh_state);
          8:  v = 64'(mshr.flags & imm[`CCE_NUM_FLAGS-1:0]);
          9:  v = 64'(mshr.lru_coh_state);
          10: v = 64'(mshr.owner_coh_state);
          11: v = sh_en ? 64'(sh_hits[lce]) : 64'd0;
          12: v = sh_en ? 64'(sh_ways[lce]) : 64'd0;
          13: v = sh_en ? 64'(sh_states[lce]) : 64'd0;
          default: v = '0;
        endcase
      end
      3: v = imm;
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [2:0] model_way(input int code, input int lce);
    case (code)
      8:  return mshr.way_id;
      9:  return mshr.owner_way_id;
      10: return mshr.lru_way_id;
      11: return sh_ways[lce];
      default: return (code < `CCE_NUM_GPR) ? gpr[code][2:0] : 3'd0;
    endcase
  endfunction

  task automatic compute_expected();
    int lce_a;
    int lce_b;
    int c;
    logic [2:0] raw;
    // group a follows the src_b register, group b the src_a register
    lce_a = lce_of_gpr(int'(src_b));
    lce_b = lce_of_gpr(int'(src_a));
    exp_src_a = model_operand(int'(src_a_sel), int'(src_a), 1'b1, lce_a);
    exp_src_b = model_operand(int'(src_b_sel), int'(src_b), 1'b0, lce_a);
    c = int'(addr_sel);
    exp_addr = '0;
    exp_bypass = 1'b0;
    if (c < `CCE_NUM_GPR) begin
      exp_addr = gpr[c][`CCE_PADDR_WIDTH-1:0];
      exp_bypass = 1'b1;
    end else if (c == 8) begin
      exp_addr = mshr.paddr;
    end else if (c == 9) begin
      exp_addr = mshr.lru_paddr;
    end else if (c == 10) begin
      exp_bypass = 1'b1;
    end
    c = int'(lce_sel);
    if (c < `CCE_NUM_GPR) exp_lce = gpr[c][`CCE_LCE_ID_WIDTH-1:0];
    else if (c == 8) exp_lce = mshr.lce_id;
    else if (c == 9) exp_lce = mshr.owner_lce_id;
    else exp_lce = '0;
    exp_way = model_way(int'(way_sel), lce_b);
    exp_lru_way = model_way(int'(lru_way_sel), lce_b);
    c = int'(coh_sel);
    case (c)
      8:  raw = mshr.next_coh_state;
      9:  raw = mshr.lru_coh_state;
      10: raw = sh_states[lce_b];
      11: raw = mshr.owner_coh_state;
      12: raw = imm[2:0];
      default: raw = (c < `CCE_NUM_GPR) ? gpr[c][2:0] : 3'd0;
    endcase
    // encodings 6 and 7 are no state and read as I
    exp_state = (raw > 3'd5) ? 3'd0 : raw;
  endtask

  // inputs are set 1 ns after an edge, results checked 1 ns after the next
  task automatic apply_and_check();
    compute_expected();
    @(posedge clk_i);
    #1;
    check_outputs();
  endtask

  task automatic randomize_data();
    for (int r = 0; r < `CCE_NUM_GPR; r++) begin
      gpr[r] = {$random(seed), $random(seed)};
    end
    imm = {$random(seed), $random(seed)};
    mshr.lce_id = 2'($random(seed));
    mshr.owner_lce_id = 2'($random(seed));
    mshr.paddr = {8'($random(seed)), 32'($random(seed))};
    mshr.lru_paddr = {8'($random(seed)), 32'($random(seed))};
    mshr.way_id = 3'($random(seed));
    mshr.lru_way_id = 3'($random(seed));
    mshr.owner_way_id = 3'($random(seed));
    mshr.next_coh_state = rand_state();
    mshr.lru_coh_state = rand_state();
    mshr.owner_coh_state = rand_state();
    mshr.flags = 13'($random(seed));
    sh_hits = 4'($random(seed));
    for (int l = 0; l < `CCE_NUM_LCE; l++) begin
      sh_ways[l] = 3'($random(seed));
      sh_states[l] = rand_state();
    end
  endtask

  task automatic init_inputs();
    src_a_sel = cce_pkg::e_src_sel_zero;
    src_b_sel = cce_pkg::e_src_sel_zero;
    src_a = '0;
    src_b = '0;
    addr_sel = cce_pkg::e_mux_sel_addr_0;
    lce_sel = cce_pkg::e_mux_sel_lce_0;
    way_sel = cce_pkg::e_mux_sel_way_0;
    lru_way_sel = cce_pkg::e_mux_sel_way_0;
    coh_sel = cce_pkg::e_mux_sel_coh_r0;
    gpr = '0;
    imm = '0;
    mshr = '0;
    sh_hits = '0;
    sh_ways = '0;
    for (int l = 0; l < `CCE_NUM_LCE; l++) begin
      sh_states[l] = cce_pkg::e_coh_i;
    end
  endtask

  task automatic test_reset();
    exp_src_a = '0;
    exp_src_b = '0;
    exp_addr = '0;
    exp_bypass = 1'b0;
    exp_lce = '0;
    exp_way = '0;
    exp_lru_way = '0;
    exp_state = 3'd0;
    // non-zero sources on every output during reset
    randomize_data();
    gpr[2][0] = 1'b1;
    imm[2:0] = 3'd3;
    mshr.lce_id = 2'd2;
    mshr.way_id = 3'd5;
    mshr.lru_way_id = 3'd6;
    src_a_sel = cce_pkg::e_src_sel_gpr;
    src_b_sel = cce_pkg::e_src_sel_imm;
    src_a = 4'd2;
    src_b = '0;
    addr_sel = cce_pkg::e_mux_sel_addr_r2;
    lce_sel = cce_pkg::e_mux_sel_lce_mshr_req;
    way_sel = cce_pkg::e_mux_sel_way_mshr_req;
    lru_way_sel = cce_pkg::e_mux_sel_way_mshr_lru;
    coh_sel = cce_pkg::e_mux_sel_coh_imm;
    repeat (RESET_CYCLES / 2) @(posedge clk_i);
    #1;
    check_outputs();
    repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_outputs();
  endtask

  task automatic test_gpr_imm();
    randomize_data();
    src_a_sel = cce_pkg::e_src_sel_gpr;
    src_b_sel = cce_pkg::e_src_sel_gpr;
    for (int r = 0; r < `CCE_NUM_GPR; r++) begin
      src_a = 4'(r);
      src_b = 4'(7 - r);
      apply_and_check();
    end
    // a register code past r7
    src_a = 4'd9;
    apply_and_check();
    src_a_sel = cce_pkg::e_src_sel_imm;
    src_b_sel = cce_pkg::e_src_sel_zero;
    apply_and_check();
    src_a_sel = cce_pkg::e_src_sel_zero;
    src_b_sel = cce_pkg::e_src_sel_imm;
    apply_and_check();
  endtask

  task automatic test_mshr_operands();
    randomize_data();
    src_a_sel = cce_pkg::e_src_sel_flag;
    src_b_sel = cce_pkg::e_src_sel_flag;
    for (int f = 0; f < `CCE_NUM_FLAGS; f++) begin
      src_a = 4'(f);
      src_b = 4'(12 - f);
      apply_and_check();
    end
    src_a_sel = cce_pkg::e_src_sel_special;
    src_b_sel = cce_pkg::e_src_sel_special;
    // field codes, the masked flags, and the two unused codes
    for (int c = 0; c < 16; c++) begin
      if (c < 11 || c > 13) begin
        src_a = 4'(c);
        src_b = 4'(c);
        apply_and_check();
      end
    end
  endtask

  task automatic test_sharers();
    randomize_data();
    sh_hits = 4'b1010;
    // each register names a known LCE
    for (int r = 0; r < `CCE_NUM_GPR; r++) begin
      gpr[r][1:0] = 2'(r);
    end
    src_a_sel = cce_pkg::e_src_sel_special;
    src_b_sel = cce_pkg::e_src_sel_gpr;
    for (int c = 11; c <= 13; c++) begin
      for (int r = 0; r < `CCE_NUM_GPR; r++) begin
        src_a = 4'(c);
        src_b = 4'(r);
        apply_and_check();
      end
    end
    src_a_sel = cce_pkg::e_src_sel_gpr;
    src_b_sel = cce_pkg::e_src_sel_special;
    for (int c = 11; c <= 13; c++) begin
      src_a = 4'(c - 10);
      src_b = 4'(c);
      apply_and_check();
    end
  endtask

  task automatic test_fu_selects();
    randomize_data();
    for (int c = 0; c < 16; c++) begin
      addr_sel = cce_pkg::cce_mux_sel_addr_e'(4'(c));
      lce_sel = cce_pkg::cce_mux_sel_lce_e'(4'(c));
      way_sel = cce_pkg::cce_mux_sel_way_e'(4'(c));
      lru_way_sel = cce_pkg::cce_mux_sel_way_e'(4'(15 - c));
      coh_sel = cce_pkg::cce_mux_sel_coh_e'(4'(c));
      // src_a code picks the register behind sharer way and state
      src_a = 4'(c);
      apply_and_check();
    end
    coh_sel = cce_pkg::e_mux_sel_coh_imm;
    for (int s = 0; s < 8; s++) begin
      imm[2:0] = 3'(s);
      apply_and_check();
    end
  endtask

  task automatic test_streaming();
    for (int n = 0; n < 50; n++) begin
      randomize_data();
      src_a_sel = cce_pkg::cce_src_sel_e'(3'($random(seed)));
      src_b_sel = cce_pkg::cce_src_sel_e'(3'($random(seed)));
      src_a = 4'($random(seed));
      src_b = 4'($random(seed));
      addr_sel = cce_pkg::cce_mux_sel_addr_e'(4'($random(seed)));
      lce_sel = cce_pkg::cce_mux_sel_lce_e'(4'($random(seed)));
      way_sel = cce_pkg::cce_mux_sel_way_e'(4'($random(seed)));
      lru_way_sel = cce_pkg::cce_mux_sel_way_e'(4'($random(seed)));
      coh_sel = cce_pkg::cce_mux_sel_coh_e'(4'($random(seed)));
      apply_and_check();
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    seed = 32'hfbae_ef8b;
    error_count = 0;
    check_count = 0;
    arst_n_i = 1'b0;
    init_inputs();
    test_reset();
    test_gpr_imm();
    test_mshr_operands();
    test_sharers();
    test_fu_selects();
    test_streaming();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
